// File: access_check.sv
`timescale 1ns/1ps

module access_check (
    input  logic                      req,
    input  mem_access_pkg::access_op_e op,
    input  logic [31:0]               vaddr,
    input  logic                      mapped,
    input  logic                      tlb_found,
    input  logic                      tlb_v,
    input  logic                      tlb_d,
    input  logic                      sc_ok,
    output logic                      exc,
    output mem_access_pkg::exc_code_t exc_code,
    output logic                      tlb_refill,
    output logic                      kills_write
);
    import mem_access_pkg::*;

    logic is_store;
    logic is_half;
    logic is_word;
    logic misalign;
    logic tlb_chk;
    logic tlb_inval;
    logic tlb_mod;

    always_comb begin
        is_store = op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR, OP_SC};
        is_half  = op inside {OP_LH, OP_LHU, OP_SH};
        is_word  = op inside {OP_LW, OP_LL, OP_SW, OP_SC};
    end

    assign misalign = req && ((is_half && vaddr[0]) || (is_word && vaddr[1:0] != 2'b00));

    assign kills_write = req && op == OP_SC && !sc_ok;

    // a failed SC never reaches memory, so the TLB is not consulted
    assign tlb_chk    = req && mapped && !misalign && !kills_write;
    assign tlb_refill = tlb_chk && !tlb_found;
    assign tlb_inval  = tlb_chk && tlb_found && !tlb_v;
    assign tlb_mod    = tlb_chk && is_store && tlb_found && tlb_v && !tlb_d;

    assign exc = misalign || tlb_refill || tlb_inval || tlb_mod;

    always_comb begin
        if (misalign)
            exc_code = is_store ? EXC_ADES : EXC_ADEL;   // alignment wins
        else if (tlb_mod)
            exc_code = EXC_MOD;
        else if (tlb_refill || tlb_inval)
            exc_code = is_store ? EXC_TLBS : EXC_TLBL;
        else
            exc_code = '0;
    end

    // kseg0 and kseg1 both start with 2'b10, never mapped
    always_comb begin
        assert final (!(mapped && vaddr[31:30] == 2'b10))
            else $error("kseg0/kseg1 address reported as mapped");
    end

endmodule

// File: access_issue.sv
`timescale 1ns/1ps

module access_issue (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req,
    input  logic                      exc,
    input  mem_access_pkg::exc_code_t exc_code,
    input  logic                      tlb_refill,
    input  logic                      kills_write,
    input  logic                      uncached,
    input  logic [31:0]               paddr,
    input  logic [31:0]               vaddr,
    input  mem_access_pkg::wstrb_t    wstrb,
    input  logic [31:0]               wdata,
    input  logic                      is_sc,
    output logic                      done,
    output logic                      cache_req,
    output logic                      uncache_req,
    output logic                      exc_out,
    output mem_access_pkg::exc_code_t exc_code_out,
    output logic                      tlb_refill_out,
    output logic [31:0]               badvaddr,
    output logic [31:0]               paddr_out,
    output mem_access_pkg::wstrb_t    wstrb_out,
    output logic [31:0]               wdata_out,
    output logic                      sc_result
);
    logic issue;

    assign issue = req && !exc && !kills_write;   // goes out to memory

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done           <= 1'b0;
            cache_req      <= 1'b0;
            uncache_req    <= 1'b0;
            exc_out        <= 1'b0;
            tlb_refill_out <= 1'b0;
            sc_result      <= 1'b0;
        end else begin
            done           <= req;
            cache_req      <= issue && !uncached;
            uncache_req    <= issue && uncached;
            exc_out        <= req && exc;
            tlb_refill_out <= req && tlb_refill;
            sc_result      <= issue && is_sc;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            exc_code_out <= exc_code;
            paddr_out    <= paddr;
            wstrb_out    <= issue ? wstrb : 4'b0000;
            wdata_out    <= wdata;
        end
        if (req && exc)
            badvaddr <= vaddr;   // holds the last faulting address
    end

    a_refill_is_exc: assert property (@(posedge clk) disable iff (!rst_n)
        tlb_refill_out |-> exc_out)
        else $error("TLB refill reported without an exception");

    a_kill_only_sc: assert property (@(posedge clk) disable iff (!rst_n)
        req && kills_write |-> is_sc)
        else $error("write killed on an access that is not an SC");

endmodule

// File: addr_translate.sv
`timescale 1ns/1ps

module addr_translate (
    input  mem_addr_pkg::vaddr_u vaddr,
    input  mem_addr_pkg::pfn_t   tlb_pfn,
    input  mem_addr_pkg::cattr_t tlb_cattr,
    input  mem_addr_pkg::cattr_t k0_cattr,
    output logic [31:0]          paddr,
    output logic                 mapped,
    output logic                 uncached
);
    import mem_addr_pkg::*;

    logic kseg0;
    logic kseg1;

    assign kseg0  = (vaddr.seg_view.seg == SEG_KSEG0);
    assign kseg1  = (vaddr.seg_view.seg == SEG_KSEG1);
    assign mapped = !(kseg0 || kseg1);   // kuseg, kseg2 and kseg3 go through the TLB

    // unmapped windows drop the segment bits
    assign paddr = mapped ? {tlb_pfn, vaddr.page_view.poff}
                          : {3'b000, vaddr.seg_view.offset};

    assign uncached = kseg1
                   || (kseg0 && k0_cattr != CATTR_CACHEABLE)
                   || (mapped && tlb_cattr != CATTR_CACHEABLE);

endmodule

// File: flist.f
mem_addr_pkg.sv
mem_access_pkg.sv
addr_translate.sv
access_check.sv
store_lane.sv
ll_sc_monitor.sv
access_issue.sv
mem_stage_top.sv
tb_mem_stage.sv

// File: ll_sc_monitor.sv
`timescale 1ns/1ps

module ll_sc_monitor (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req,
    input  mem_access_pkg::access_op_e op,
    input  logic [31:0]               vaddr,
    input  logic                      exc_other,
    output logic                      sc_ok
);
    import mem_access_pkg::*;

    localparam logic UNLINKED = 1'b0;
    localparam logic LINKED   = 1'b1;

    logic        state;
    logic        state_nxt;
    logic [31:0] link_addr;

    assign sc_ok = req && op == OP_SC && state == LINKED && vaddr == link_addr;

    always_comb begin
        state_nxt = state;
        if (req) begin
            if (exc_other || op == OP_SC)
                state_nxt = UNLINKED;   // any SC consumes the link
            else if (op == OP_LL)
                state_nxt = LINKED;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= UNLINKED;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk) begin
        if (req && op == OP_LL && !exc_other)
            link_addr <= vaddr;
    end

    // only an aligned LL can set the link
    a_link_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        state == LINKED |-> link_addr[1:0] == 2'b00)
        else $error("link held on a misaligned address");

endmodule

// File: mem_access_pkg.sv
package mem_access_pkg;

    typedef enum logic [3:0] {
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_LL,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_SWL,
        OP_SWR,
        OP_SC
    } access_op_e;

    typedef logic [4:0] exc_code_t;

    // Cause.ExcCode values
    localparam exc_code_t EXC_MOD  = 5'd1;
    localparam exc_code_t EXC_TLBL = 5'd2;
    localparam exc_code_t EXC_TLBS = 5'd3;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;

    typedef logic [3:0] wstrb_t;

endpackage

// File: mem_addr_pkg.sv
package mem_addr_pkg;

    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cattr_t;

    localparam cattr_t CATTR_CACHEABLE = 3'd3;

    // top three address bits pick the segment
    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    typedef struct packed {
        logic [2:0]  seg;
        logic [28:0] offset;
    } seg_view_t;

    typedef struct packed {
        logic [19:0] vpn;     // what the TLB was looked up with
        logic [11:0] poff;
    } page_view_t;

    // one virtual address word, read by segment when unmapped, by page when mapped
    typedef union packed {
        seg_view_t  seg_view;
        page_view_t page_view;
    } vaddr_u;

endpackage

// File: mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req,
    input  mem_access_pkg::access_op_e op,
    input  logic [31:0]               vaddr,
    input  logic [31:0]               rt_data,
    input  logic                      tlb_found,
    input  logic                      tlb_v,
    input  logic                      tlb_d,
    input  mem_addr_pkg::pfn_t        tlb_pfn,
    input  mem_addr_pkg::cattr_t      tlb_cattr,
    input  mem_addr_pkg::cattr_t      k0_cattr,
    output logic                      done,
    output logic                      exc,
    output mem_access_pkg::exc_code_t exc_code,
    output logic                      tlb_refill,
    output logic [31:0]               badvaddr,
    output logic                      cache_req,
    output logic                      uncache_req,
    output logic [31:0]               paddr,
    output mem_access_pkg::wstrb_t    wstrb,
    output logic [31:0]               wdata,
    output logic                      sc_result
);
    import mem_access_pkg::*;

    logic [31:0] paddr_c;
    logic        mapped;
    logic        uncached;
    logic        exc_c;
    exc_code_t   exc_code_c;
    logic        tlb_refill_c;
    logic        kills_write;
    logic        sc_ok;
    wstrb_t      wstrb_c;
    logic [31:0] wdata_c;
    logic        is_sc;

    assign is_sc = (op == OP_SC);

    addr_translate addr_translate_inst (
        .vaddr     (vaddr),
        .tlb_pfn   (tlb_pfn),
        .tlb_cattr (tlb_cattr),
        .k0_cattr  (k0_cattr),
        .paddr     (paddr_c),
        .mapped    (mapped),
        .uncached  (uncached)
    );

    access_check access_check_inst (
        .req         (req),
        .op          (op),
        .vaddr       (vaddr),
        .mapped      (mapped),
        .tlb_found   (tlb_found),
        .tlb_v       (tlb_v),
        .tlb_d       (tlb_d),
        .sc_ok       (sc_ok),
        .exc         (exc_c),
        .exc_code    (exc_code_c),
        .tlb_refill  (tlb_refill_c),
        .kills_write (kills_write)
    );

    store_lane store_lane_inst (
        .op      (op),
        .addr_lo (vaddr[1:0]),   // page offset, same in paddr
        .rt_data (rt_data),
        .wstrb   (wstrb_c),
        .wdata   (wdata_c)
    );

    ll_sc_monitor ll_sc_monitor_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .op        (op),
        .vaddr     (vaddr),
        .exc_other (exc_c),
        .sc_ok     (sc_ok)
    );

    access_issue access_issue_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (req),
        .exc            (exc_c),
        .exc_code       (exc_code_c),
        .tlb_refill     (tlb_refill_c),
        .kills_write    (kills_write),
        .uncached       (uncached),
        .paddr          (paddr_c),
        .vaddr          (vaddr),
        .wstrb          (wstrb_c),
        .wdata          (wdata_c),
        .is_sc          (is_sc),
        .done           (done),
        .cache_req      (cache_req),
        .uncache_req    (uncache_req),
        .exc_out        (exc),
        .exc_code_out   (exc_code),
        .tlb_refill_out (tlb_refill),
        .badvaddr       (badvaddr),
        .paddr_out      (paddr),
        .wstrb_out      (wstrb),
        .wdata_out      (wdata),
        .sc_result      (sc_result)
    );

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_stage \
    -f flist.f -o tb_mem_stage_sim

./obj_dir/tb_mem_stage_sim | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "run passed"
else
    echo "run failed"
    exit 1
fi

// File: store_lane.sv
`timescale 1ns/1ps

module store_lane (
    input  mem_access_pkg::access_op_e op,
    input  logic [1:0]                addr_lo,
    input  logic [31:0]               rt_data,
    output mem_access_pkg::wstrb_t    wstrb,
    output logic [31:0]               wdata
);
    import mem_access_pkg::*;

    always_comb begin
        wdata = rt_data;
        case (op)
            OP_SB:        wstrb = 4'b0001 << addr_lo;
            OP_SH:        wstrb = addr_lo[1] ? 4'b1100 : 4'b0011;
            OP_SW, OP_SC: wstrb = 4'b1111;
            OP_SWL: begin
                // high end of rt into the low lanes
                case (addr_lo)
                    2'b00: begin
                        wstrb = 4'b0001;
                        wdata = {4{rt_data[31:24]}};
                    end
                    2'b01: begin
                        wstrb = 4'b0011;
                        wdata = {2{rt_data[31:16]}};
                    end
                    2'b10: begin
                        wstrb = 4'b0111;
                        wdata = {8'b0, rt_data[31:8]};
                    end
                    default: wstrb = 4'b1111;
                endcase
            end
            OP_SWR: begin
                case (addr_lo)
                    2'b00: wstrb = 4'b1111;
                    2'b01: begin
                        wstrb = 4'b1110;
                        wdata = {rt_data[23:0], 8'b0};
                    end
                    2'b10: begin
                        wstrb = 4'b1100;
                        wdata = {2{rt_data[15:0]}};
                    end
                    default: begin
                        wstrb = 4'b1000;
                        wdata = {4{rt_data[7:0]}};
                    end
                endcase
            end
            default:      wstrb = 4'b0000;   // loads
        endcase
    end

endmodule

// File: tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;
    import mem_addr_pkg::*;
    import mem_access_pkg::*;

    localparam int NUM_REQ        = 2000;
    localparam int TIMEOUT_CYCLES = 2 * NUM_REQ + 20;

    typedef struct packed {
        logic        valid;
        logic        exc;
        exc_code_t   code;
        logic        refill;
        logic [31:0] badvaddr;
        logic        cache;
        logic        uncache;
        logic [31:0] paddr;
        wstrb_t      wstrb;
        logic [31:0] wdata;
        logic        chk_data;   // only stores that go out carry data
        logic        sc;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        req;
    access_op_e  op;
    logic [31:0] vaddr;
    logic [31:0] rt_data;
    logic        tlb_found;
    logic        tlb_v;
    logic        tlb_d;
    pfn_t        tlb_pfn;
    cattr_t      tlb_cattr;
    cattr_t      k0_cattr;

    logic        done;
    logic        exc;
    exc_code_t   exc_code;
    logic        tlb_refill;
    logic [31:0] badvaddr;
    logic        cache_req;
    logic        uncache_req;
    logic [31:0] paddr;
    wstrb_t      wstrb;
    logic [31:0] wdata;
    logic        sc_result;

    integer      seed = 21;
    int          req_count = 0;
    int          cycle_count = 0;
    int          errors = 0;
    logic        link_set = 1'b0;   // reference copy of the LL/SC link
    logic [31:0] link_addr = '0;
    expect_t     exp_q[$];

    mem_stage_top mem_stage_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .op          (op),
        .vaddr       (vaddr),
        .rt_data     (rt_data),
        .tlb_found   (tlb_found),
        .tlb_v       (tlb_v),
        .tlb_d       (tlb_d),
        .tlb_pfn     (tlb_pfn),
        .tlb_cattr   (tlb_cattr),
        .k0_cattr    (k0_cattr),
        .done        (done),
        .exc         (exc),
        .exc_code    (exc_code),
        .tlb_refill  (tlb_refill),
        .badvaddr    (badvaddr),
        .cache_req   (cache_req),
        .uncache_req (uncache_req),
        .paddr       (paddr),
        .wstrb       (wstrb),
        .wdata       (wdata),
        .sc_result   (sc_result)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
            report_failure();
        end
    end

    task automatic report_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic show_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        errors++;
        $display("[ERROR] %s expected 0x%h got 0x%h at %0t", name, expected, actual, $time);
        report_failure();
    endtask

    task automatic check_path(input logic exp_done, input logic exp_cache,
                              input logic exp_uncache, input logic exp_sc);
        if (done !== exp_done)
            show_mismatch("done", 32'(exp_done), 32'(done));
        else if (cache_req !== exp_cache)
            show_mismatch("cache_req", 32'(exp_cache), 32'(cache_req));
        else if (uncache_req !== exp_uncache)
            show_mismatch("uncache_req", 32'(exp_uncache), 32'(uncache_req));
        else if (sc_result !== exp_sc)
            show_mismatch("sc_result", 32'(exp_sc), 32'(sc_result));
    endtask

    task automatic check_exc(input logic exp_exc, input exc_code_t exp_code,
                             input logic exp_refill);
        if (exc !== exp_exc)
            show_mismatch("exc", 32'(exp_exc), 32'(exc));
        else if (tlb_refill !== exp_refill)
            show_mismatch("tlb_refill", 32'(exp_refill), 32'(tlb_refill));
        else if (exp_exc && exc_code !== exp_code)
            show_mismatch("exc_code", 32'(exp_code), 32'(exc_code));
    endtask

    task automatic check_addr(input logic exp_exc, input logic [31:0] exp_paddr,
                              input logic [31:0] exp_badvaddr);
        if (exp_exc && badvaddr !== exp_badvaddr)
            show_mismatch("badvaddr", exp_badvaddr, badvaddr);
        else if (!exp_exc && paddr !== exp_paddr)
            show_mismatch("paddr", exp_paddr, paddr);
    endtask

    task automatic check_store(input wstrb_t exp_wstrb, input logic [31:0] exp_wdata,
                               input logic chk_data);
        if (wstrb !== exp_wstrb)
            show_mismatch("wstrb", 32'(exp_wstrb), 32'(wstrb));
        else if (chk_data && wdata !== exp_wdata)
            show_mismatch("wdata", exp_wdata, wdata);
    endtask

    function automatic logic [31:0] pool_addr(input logic [1:0] idx);
        case (idx)
            2'd0:    return 32'h8000_0100;   // kseg0
            2'd1:    return 32'hA000_0200;   // kseg1
            2'd2:    return 32'h0040_0300;   // kuseg
            default: return 32'hC000_0400;   // kseg2
        endcase
    endfunction

    // reference result for the request on the inputs now
    task automatic model_request();
        expect_t    e;
        logic       is_store;
        logic       is_half;
        logic       is_word;
        logic       mis;
        logic       mapped;
        logic       sc_fail;
        logic       tlb_chk;
        logic       inval;
        logic       mod;
        logic       unc;
        logic       issue;
        logic [2:0] seg;
        logic [1:0] lo;
        seg      = vaddr[31:29];
        lo       = vaddr[1:0];
        is_store = op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR, OP_SC};
        is_half  = op inside {OP_LH, OP_LHU, OP_SH};
        is_word  = op inside {OP_LW, OP_LL, OP_SW, OP_SC};
        mapped   = (seg != 3'b100) && (seg != 3'b101);
        mis      = (is_half && lo[0]) || (is_word && lo != 2'b00);
        sc_fail  = (op == OP_SC) && !(link_set && vaddr == link_addr);
        tlb_chk  = mapped && !mis && !sc_fail;
        e.valid    = 1'b1;
        e.refill   = tlb_chk && !tlb_found;
        inval      = tlb_chk && tlb_found && !tlb_v;
        mod        = tlb_chk && is_store && tlb_found && tlb_v && !tlb_d;
        e.exc      = mis || e.refill || inval || mod;
        e.badvaddr = vaddr;
        if (mis)
            e.code = is_store ? 5'd5 : 5'd4;
        else if (mod)
            e.code = 5'd1;
        else
            e.code = is_store ? 5'd3 : 5'd2;
        issue     = !e.exc && !sc_fail;
        unc       = (seg == 3'b101) || (seg == 3'b100 && k0_cattr != 3'd3)
                 || (mapped && tlb_cattr != 3'd3);
        e.cache   = issue && !unc;
        e.uncache = issue && unc;
        e.sc      = issue && op == OP_SC;
        e.paddr   = mapped ? {tlb_pfn, vaddr[11:0]} : {3'b000, vaddr[28:0]};
        e.wdata   = rt_data;
        e.wstrb   = 4'b0000;
        case (op)
            OP_SB:        e.wstrb = 4'b0001 << lo;
            OP_SH:        e.wstrb = lo[1] ? 4'b1100 : 4'b0011;
            OP_SW, OP_SC: e.wstrb = 4'b1111;
            OP_SWL: begin
                e.wstrb = {lo == 2'b11, lo >= 2'b10, lo != 2'b00, 1'b1};
                if (lo == 2'b00)
                    e.wdata = {4{rt_data[31:24]}};
                else if (lo == 2'b01)
                    e.wdata = {2{rt_data[31:16]}};
                else if (lo == 2'b10)
                    e.wdata = {8'h00, rt_data[31:8]};
            end
            OP_SWR: begin
                e.wstrb = {1'b1, lo != 2'b11, lo <= 2'b01, lo == 2'b00};
                if (lo == 2'b01)
                    e.wdata = {rt_data[23:0], 8'h00};
                else if (lo == 2'b10)
                    e.wdata = {2{rt_data[15:0]}};
                else if (lo == 2'b11)
                    e.wdata = {4{rt_data[7:0]}};
            end
            default: ;
        endcase
        if (!issue)
            e.wstrb = 4'b0000;
        e.chk_data = issue && is_store;
        if (e.exc || op == OP_SC)
            link_set = 1'b0;
        else if (op == OP_LL) begin
            link_set  = 1'b1;
            link_addr = vaddr;
        end
        exp_q.push_back(e);
    endtask

    task automatic drive_cycle();
        logic [31:0] r;
        logic [31:0] pick;
        expect_t     idle;
        r   = $random(seed);
        req = (r[3:0] < 4'd13);   // roughly 80 % busy
        if (r[7:4] < 4'd12)
            op = access_op_e'(r[7:4]);
        else
            op = r[4] ? OP_LL : OP_SC;   // extra LL/SC traffic
        pick = $random(seed);
        if (pick[0])
            vaddr = pool_addr(pick[2:1]);
        else
            vaddr = $random(seed);
        vaddr[1:0] = 2'b00;
        if (pick[4:3] == 2'b00)
            vaddr[1:0] = (pick[6:5] == 2'b00) ? 2'b01 : pick[6:5];
        rt_data   = $random(seed);
        r         = $random(seed);
        tlb_found = (r[2:0] != 3'b000);
        tlb_v     = (r[5:3] != 3'b000);
        tlb_d     = (r[7:6] != 2'b00);
        tlb_cattr = r[8] ? 3'd3 : r[11:9];
        tlb_pfn   = r[31:12];
        if (req) begin
            req_count++;
            model_request();
        end else begin
            idle = '0;
            exp_q.push_back(idle);
        end
    endtask

    task automatic check_outputs();
        expect_t e;
        if (exp_q.size() == 0) begin
            $display("no expected result was queued for this cycle");
            report_failure();
        end else begin
            e = exp_q.pop_front();
            check_path(e.valid, e.cache, e.uncache, e.sc);
            check_exc(e.exc, e.code, e.refill);
            if (e.valid) begin
                check_addr(e.exc, e.paddr, e.badvaddr);
                check_store(e.wstrb, e.wdata, e.chk_data);
            end
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        req       = 1'b0;
        op        = OP_LB;
        vaddr     = '0;
        rt_data   = '0;
        tlb_found = 1'b0;
        tlb_v     = 1'b0;
        tlb_d     = 1'b0;
        tlb_pfn   = '0;
        tlb_cattr = 3'd3;
        k0_cattr  = 3'd3;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_path(1'b0, 1'b0, 1'b0, 1'b0);
        check_exc(1'b0, '0, 1'b0);

        while (req_count < NUM_REQ) begin
            if (req_count >= NUM_REQ / 2)
                k0_cattr = 3'd2;   // second half, kseg0 goes uncached
            drive_cycle();
            @(negedge clk);
            check_outputs();
        end
        req = 1'b0;

        if (errors == 0 && exp_q.size() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            report_failure();
        end
    end

endmodule
